// File: hw/d1_defines.svh
`ifndef D1_DEFINES_SVH
`define D1_DEFINES_SVH

// ------------------------------------------------------------------------
// Decode stage one sizing
// ------------------------------------------------------------------------

// Instruction and address width
`define D1_XLEN 32

// Instruction buffer line, 64 bytes
`define D1_LINE_BITS 512

// One valid bit per 128-bit region of the line
`define D1_REGIONS 4

// Global history length, also the pattern table index width
`define D1_BHR_BITS 10

`endif

// File: hw/d1_fetch_pkg.sv
`include "d1_defines.svh"

package d1_fetch_pkg;

    // --------------------------------------------------------------------
    // Predecode encodings
    // --------------------------------------------------------------------

    // Instruction format as seen by the predecoder
    typedef enum logic [2:0]
    {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_COMPRESSED,
        FMT_ILLEGAL
    } opcode_format_e;

    // Major opcodes of the 32-bit base ISA, bits 6:0
    typedef enum logic [6:0]
    {
        OP_OP       = 7'b0110011,
        OP_IMM      = 7'b0010011,
        OP_LOAD     = 7'b0000011,
        OP_JALR     = 7'b1100111,
        OP_SYSTEM   = 7'b1110011,
        OP_MISC_MEM = 7'b0001111,
        OP_STORE    = 7'b0100011,
        OP_BRANCH   = 7'b1100011,
        OP_LUI      = 7'b0110111,
        OP_AUIPC    = 7'b0010111,
        OP_JAL      = 7'b1101111
    } opcode_e;

    // --------------------------------------------------------------------
    // Items entering and leaving D1
    // --------------------------------------------------------------------

    // Fetched line, byte 0 sits in bits 511:504
    typedef struct packed
    {
        logic [`D1_LINE_BITS-1:0] line;
        logic [`D1_REGIONS-1:0]   region_valid;
        logic [`D1_XLEN-1:0]      pc;
        logic                     exception;
    } fetch_line_t;

    // Predecode result offered to the next stage
    typedef struct packed
    {
        logic [`D1_XLEN-1:0] pc;
        logic [`D1_XLEN-1:0] instruction;
        logic                valid;
        logic                compressed;
        opcode_format_e      format;
        logic                exception;
        logic                resteer;
        logic                resteer_taken;
        logic [`D1_XLEN-1:0] resteer_target;
        logic                ras_push;
        logic                ras_pop;
        logic [`D1_XLEN-1:0] ras_ret_addr;
    } d1_result_t;

endpackage

// File: hw/d1_bp_pkg.sv
`include "d1_defines.svh"

package d1_bp_pkg;

    // --------------------------------------------------------------------
    // Pattern table types
    // --------------------------------------------------------------------

    // Saturating 2-bit counter, upper half predicts taken
    typedef enum logic [1:0]
    {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_e;

    // Training pulse from branch resolution
    // bhr is the history the branch was predicted with
    typedef struct packed
    {
        logic                    valid;
        logic                    taken;
        logic [`D1_BHR_BITS-1:0] bhr;
    } bp_update_t;

endpackage

// File: hw/byte_rotator.sv
`timescale 1ns/1ps

`include "d1_defines.svh"

module byte_rotator
(
    input  logic [`D1_LINE_BITS-1:0] data_in,
    input  logic [5:0]               shift,
    input  logic [`D1_REGIONS-1:0]   ibuff_valid,
    output logic [`D1_XLEN-1:0]      data_out,
    output logic                     valid_out
);

    // Shift amounts in bits
    logic [8:0]               bit_shift;
    logic [9:0]               back_shift;
    logic [`D1_LINE_BITS-1:0] rotated;

    // Window bounds in the unrotated line
    logic [8:0]               start_index;
    logic [8:0]               end_index;
    logic                     wraps;
    logic [1:0]               region_start;
    logic [1:0]               region_end;

    // ------------------------------------------------------------------------
    // Rotation
    // ------------------------------------------------------------------------

    // Byte offset times eight
    assign bit_shift = {shift, 3'b000};

    // Complement for the wrap-around half, 512 at shift zero drops everything
    assign back_shift = 10'(`D1_LINE_BITS) - {1'b0, bit_shift};

    // Rotate left so the byte at the offset lands in the top byte
    assign rotated = (data_in << bit_shift) | (data_in >> back_shift);

    // Window is the top XLEN bits
    assign data_out = rotated[`D1_LINE_BITS-1 -: `D1_XLEN];

    // ------------------------------------------------------------------------
    // Validity
    // ------------------------------------------------------------------------

    // MSB of the window in the original line
    assign start_index = 9'(`D1_LINE_BITS - 1) - bit_shift;

    // Fewer than XLEN bits left below the start means a wrap
    assign wraps = start_index < 9'(`D1_XLEN - 1);

    // LSB of the window, only meaningful without a wrap
    assign end_index = start_index - 9'(`D1_XLEN - 1);

    // Region 0 is the top quarter, so invert the two top index bits
    assign region_start = ~start_index[8:7];
    assign region_end   = ~end_index[8:7];

    // Whole window inside one valid region
    assign valid_out = !wraps
                       && (region_start == region_end)
                       && ibuff_valid[region_start];

endmodule

// File: hw/predecoder.sv
`timescale 1ns/1ps

`include "d1_defines.svh"

module predecoder
    import d1_fetch_pkg::*;
(
    input  logic [`D1_XLEN-1:0] window,
    input  logic                window_valid,
    input  logic [`D1_XLEN-1:0] pc,
    input  logic                exception,
    input  logic                predict_taken,
    output d1_result_t          result
);

    // Instruction in memory order, byte at pc in bits 7:0
    logic [`D1_XLEN-1:0] inst;
    opcode_e             op;
    opcode_format_e      fmt;

    // Register fields and immediates
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic                rd_link;
    logic                rs1_link;
    logic [`D1_XLEN-1:0] imm_j;
    logic [`D1_XLEN-1:0] imm_b;

    // Classification
    logic                is_compressed;
    logic                is_jal;
    logic                is_jalr;
    logic                is_branch;
    logic                cf_ok;

    // ------------------------------------------------------------------------
    // Field extraction
    // ------------------------------------------------------------------------

    // Window top byte is the byte at pc, little endian needs a byte swap
    assign inst = {window[7:0], window[15:8], window[23:16], window[31:24]};

    assign op            = opcode_e'(inst[6:0]);
    assign is_compressed = inst[1:0] != 2'b11;

    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];

    // x1 and x5 are the link registers
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    // J immediate, imm[20|10:1|11|19:12]
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // B immediate, imm[12|10:5] and imm[4:1|11]
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    assign is_jal    = !is_compressed && (op == OP_JAL);
    assign is_jalr   = !is_compressed && (op == OP_JALR);
    assign is_branch = !is_compressed && (op == OP_BRANCH);

    // Control flow only from a clean, valid window
    assign cf_ok = window_valid && !exception;

    // ------------------------------------------------------------------------
    // Format decode
    // ------------------------------------------------------------------------

    always_comb
    begin
        if (is_compressed)
        begin
            // RVC is only flagged here
            fmt = FMT_COMPRESSED;
        end
        else
        begin
            case (op)
                OP_OP:
                    fmt = FMT_R;
                OP_IMM, OP_LOAD, OP_JALR, OP_SYSTEM, OP_MISC_MEM:
                    fmt = FMT_I;
                OP_STORE:
                    fmt = FMT_S;
                OP_BRANCH:
                    fmt = FMT_B;
                OP_LUI, OP_AUIPC:
                    fmt = FMT_U;
                OP_JAL:
                    fmt = FMT_J;
                default:
                    fmt = FMT_ILLEGAL;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Result and early resteer
    // ------------------------------------------------------------------------

    always_comb
    begin
        result             = '0;
        result.pc          = pc;
        result.instruction = inst;
        result.valid       = window_valid;
        result.compressed  = is_compressed;
        result.format      = fmt;
        result.exception   = exception;

        if (cf_ok)
        begin
            // Fall-through address for a call
            result.ras_ret_addr = is_compressed ? pc + `D1_XLEN'(2) : pc + `D1_XLEN'(4);

            // Direct jump always redirects
            if (is_jal)
            begin
                result.resteer        = 1'b1;
                result.resteer_taken  = 1'b1;
                result.resteer_target = pc + imm_j;
            end
            // Conditional branch only on a taken prediction
            else if (is_branch && predict_taken)
            begin
                result.resteer        = 1'b1;
                result.resteer_taken  = 1'b1;
                result.resteer_target = pc + imm_b;
            end

            // Call writes a link register
            result.ras_push = (is_jal || is_jalr) && rd_link;

            // Return reads a link and writes none
            result.ras_pop = is_jalr && rs1_link && !rd_link;
        end
    end

endmodule

// File: hw/branch_pht.sv
`timescale 1ns/1ps

`include "d1_defines.svh"

module branch_pht
    import d1_bp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  bp_update_t upd,
    output logic       predict_taken
);

    // Global history, newest outcome in bit 0
    logic [`D1_BHR_BITS-1:0] bhr;

    // One counter per history pattern
    counter_e pht [(1 << `D1_BHR_BITS)-1:0];

    // Saturating step toward the outcome
    function automatic counter_e count_step(counter_e cur, logic taken);
        counter_e nxt;
        nxt = cur;
        case (cur)
            STRONG_NT:
                nxt = taken ? WEAK_NT : STRONG_NT;
            WEAK_NT:
                nxt = taken ? WEAK_T : STRONG_NT;
            WEAK_T:
                nxt = taken ? STRONG_T : WEAK_NT;
            STRONG_T:
                nxt = taken ? STRONG_T : WEAK_T;
            default:
                nxt = WEAK_NT;
        endcase
        return nxt;
    endfunction

    // ------------------------------------------------------------------------
    // Lookup, combinational from the current history
    // ------------------------------------------------------------------------

    assign predict_taken = pht[bhr] >= WEAK_T;

    // ------------------------------------------------------------------------
    // Training
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bhr <= '0;
            // Start every pattern weakly not taken
            for (int i = 0; i < (1 << `D1_BHR_BITS); i++)
                pht[i] <= WEAK_NT;
        end
        else if (upd.valid)
        begin
            // Counter indexed by the history the branch saw
            pht[upd.bhr] <= count_step(pht[upd.bhr], upd.taken);
            // History repaired from the update, outcome shifted in
            bhr <= {upd.bhr[`D1_BHR_BITS-2:0], upd.taken};
        end
    end

endmodule

// File: hw/d1_stage.sv
`timescale 1ns/1ps

`include "d1_defines.svh"

module d1_stage
    import d1_fetch_pkg::*;
    import d1_bp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Fetch side, four-phase
    input  logic        in_req,
    output logic        in_ack,
    input  fetch_line_t in_line,

    // Flush pulse from the back end
    input  logic        resteer,

    // Predictor training pulse
    input  bp_update_t  bp_upd,

    // Consumer side, four-phase
    output logic        out_req,
    input  logic        out_ack,
    output d1_result_t  out_result
);

    // Input handshake, ack held until req drops
    typedef enum logic
    {
        IN_IDLE,
        IN_ACK
    } in_state_e;

    // Output handshake, one load cycle before req
    typedef enum logic [1:0]
    {
        OUT_IDLE,
        OUT_LOAD,
        OUT_REQ,
        OUT_RELEASE
    } out_state_e;

    in_state_e           in_state;
    out_state_e          out_state;

    // Input slot
    logic                in_full;
    fetch_line_t         in_item;

    // Output slot
    d1_result_t          out_q;

    // Datapath between slots
    logic [`D1_XLEN-1:0] window;
    logic                window_valid;
    logic                pht_taken;
    d1_result_t          pd_result;

    // Slot movement
    logic                capture_fire;
    logic                out_empty;
    logic                load_fire;

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------

    // Window at the pc byte offset
    byte_rotator u_rotator
    (
        .data_in     (in_item.line),
        .shift       (in_item.pc[5:0]),
        .ibuff_valid (in_item.region_valid),
        .data_out    (window),
        .valid_out   (window_valid)
    );

    predecoder u_predecoder
    (
        .window        (window),
        .window_valid  (window_valid),
        .pc            (in_item.pc),
        .exception     (in_item.exception),
        .predict_taken (pht_taken),
        .result        (pd_result)
    );

    // Training goes straight through, no handshake
    branch_pht u_pht
    (
        .clk           (clk),
        .rst           (rst),
        .upd           (bp_upd),
        .predict_taken (pht_taken)
    );

    // ------------------------------------------------------------------------
    // Slot control
    // ------------------------------------------------------------------------

    // New item only after the previous ack phase closed and the slot drained
    assign capture_fire = (in_state == IN_IDLE) && in_req && !in_full;

    // Output slot is free once req and ack are both low
    assign out_empty = (out_state == OUT_IDLE)
                       || ((out_state == OUT_RELEASE) && !out_ack);

    // A flushed input item must not move on
    assign load_fire = in_full && out_empty && !resteer;

    assign in_ack     = in_state == IN_ACK;
    assign out_req    = out_state == OUT_REQ;
    assign out_result = out_q;

    // Input handshake FSM
    always_ff @(posedge clk)
    begin
        if (rst)
            in_state <= IN_IDLE;
        else
        begin
            case (in_state)
                IN_IDLE:
                    if (capture_fire)
                        in_state <= IN_ACK;
                IN_ACK:
                    // fetch side released, drop ack
                    if (!in_req)
                        in_state <= IN_IDLE;
                default:
                    in_state <= IN_IDLE;
            endcase
        end
    end

    // Input slot occupancy, resteer wins over a capture on the same edge
    always_ff @(posedge clk)
    begin
        if (rst)
            in_full <= 1'b0;
        else if (resteer)
            in_full <= 1'b0;
        else if (capture_fire)
            in_full <= 1'b1;
        else if (load_fire)
            in_full <= 1'b0;
    end

    // Input slot payload
    always_ff @(posedge clk)
    begin
        if (capture_fire)
            in_item <= in_line;
    end

    // Output handshake FSM
    always_ff @(posedge clk)
    begin
        if (rst)
            out_state <= OUT_IDLE;
        else
        begin
            case (out_state)
                OUT_IDLE:
                    if (load_fire)
                        out_state <= OUT_LOAD;
                OUT_LOAD:
                    // Loaded but not yet offered, still flushable
                    out_state <= resteer ? OUT_IDLE : OUT_REQ;
                OUT_REQ:
                    if (out_ack)
                        out_state <= OUT_RELEASE;
                OUT_RELEASE:
                    // Back to back load when the consumer has let go
                    if (!out_ack)
                        out_state <= load_fire ? OUT_LOAD : OUT_IDLE;
                default:
                    out_state <= OUT_IDLE;
            endcase
        end
    end

    // Output slot, cleared so resteer and ras fields read low out of reset
    always_ff @(posedge clk)
    begin
        if (rst)
            out_q <= '0;
        else if (load_fire)
            out_q <= pd_result;
    end

endmodule

// File: sim/d1_tb_model.svh
`ifndef D1_TB_MODEL_SVH
`define D1_TB_MODEL_SVH

// ------------------------------------------------------------------------
// Pattern table mirror
// ------------------------------------------------------------------------

// Counter values 0 to 3, two and up predicts taken
int unsigned             pht_ref [1 << `D1_BHR_BITS];
logic [`D1_BHR_BITS-1:0] bhr_ref;

function automatic void reset_counters();
    for (int i = 0; i < (1 << `D1_BHR_BITS); i++)
        pht_ref[i] = 1;
    bhr_ref = '0;
endfunction

// Saturate toward the outcome, then the outcome enters the history
function automatic void train_counter(logic [`D1_BHR_BITS-1:0] hist, logic taken);
    if (taken && pht_ref[hist] < 3)
        pht_ref[hist] = pht_ref[hist] + 1;
    else if (!taken && pht_ref[hist] > 0)
        pht_ref[hist] = pht_ref[hist] - 1;
    bhr_ref = (hist << 1) | taken;
endfunction

function automatic logic predict_from_history();
    return pht_ref[bhr_ref] >= 2;
endfunction

// ------------------------------------------------------------------------
// Window and predecode mirror
// ------------------------------------------------------------------------

// Byte 0 of a line is its most significant byte
function automatic logic [7:0] line_byte(logic [`D1_LINE_BITS-1:0] line, int j);
    return line[`D1_LINE_BITS-1-8*j -: 8];
endfunction

// Four bytes from the pc offset in memory order, wrapping inside the line
function automatic logic [31:0] window_bytes(fetch_line_t item);
    logic [31:0] inst;
    int          off;
    off = item.pc[5:0];
    for (int k = 0; k < 4; k++)
        inst[8*k +: 8] = line_byte(item.line, (off + k) % (`D1_LINE_BITS / 8));
    return inst;
endfunction

// No wrap, one 16-byte region, and that region valid
function automatic logic window_in_region(fetch_line_t item);
    int first;
    int last;
    first = item.pc[5:0];
    last  = first + 3;
    if (last >= `D1_LINE_BITS / 8)
        return 1'b0;
    if (first / 16 != last / 16)
        return 1'b0;
    return item.region_valid[first / 16];
endfunction

function automatic opcode_format_e format_of(logic [31:0] inst);
    if (inst[1:0] != 2'b11)
        return FMT_COMPRESSED;
    case (inst[6:0])
        7'b0110011: return FMT_R;
        7'b0010011, 7'b0000011, 7'b1100111, 7'b1110011, 7'b0001111: return FMT_I;
        7'b0100011: return FMT_S;
        7'b1100011: return FMT_B;
        7'b0110111, 7'b0010111: return FMT_U;
        7'b1101111: return FMT_J;
        default: return FMT_ILLEGAL;
    endcase
endfunction

function automatic d1_result_t expected_result(fetch_line_t item, logic taken_pred);
    d1_result_t         r;
    logic [31:0]        inst;
    logic signed [20:0] j_off;
    logic signed [12:0] b_off;
    int                 j_ext;
    int                 b_ext;
    logic               rd_is_link;
    logic               rs1_is_link;

    inst  = window_bytes(item);
    // ISA immediate layouts, sign extended through int
    j_off = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    b_off = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    j_ext = j_off;
    b_ext = b_off;
    rd_is_link  = (inst[11:7] == 5'd1) || (inst[11:7] == 5'd5);
    rs1_is_link = (inst[19:15] == 5'd1) || (inst[19:15] == 5'd5);

    r             = '0;
    r.pc          = item.pc;
    r.instruction = inst;
    r.valid       = window_in_region(item);
    r.compressed  = inst[1:0] != 2'b11;
    r.format      = format_of(inst);
    r.exception   = item.exception;

    // Resteer and return stack only for a clean window
    if (r.valid && !item.exception)
    begin
        r.ras_ret_addr = item.pc + (r.compressed ? 2 : 4);
        if (r.format == FMT_J)
        begin
            r.resteer        = 1'b1;
            r.resteer_taken  = 1'b1;
            r.resteer_target = item.pc + j_ext;
        end
        else if (r.format == FMT_B && taken_pred)
        begin
            r.resteer        = 1'b1;
            r.resteer_taken  = 1'b1;
            r.resteer_target = item.pc + b_ext;
        end
        // Compressed words never match these opcodes
        r.ras_push = (inst[6:0] == 7'b1101111 || inst[6:0] == 7'b1100111) && rd_is_link;
        r.ras_pop  = (inst[6:0] == 7'b1100111) && rs1_is_link && !rd_is_link;
    end
    return r;
endfunction

`endif

// File: sim/d1_tb.sv
`timescale 1ns/1ps

`include "d1_defines.svh"

module d1_tb
    import d1_fetch_pkg::*;
    import d1_bp_pkg::*;
();

    localparam int CLK_HALF    = 50;
    localparam int DRIVE_DELAY = 10;
    localparam int TIMEOUT     = 40;

    logic        clk;
    logic        rst;
    logic        in_req;
    logic        in_ack;
    fetch_line_t in_line;
    logic        resteer;
    bp_update_t  bp_upd;
    logic        out_req;
    logic        out_ack;
    d1_result_t  out_result;

    // Scoreboard, results in the order they must leave
    d1_result_t  expect_q [$];

    int          errors;
    int          checks;
    int          tests_done;
    int unsigned seed_draw;

    `include "d1_tb_model.svh"

    d1_stage uut
    (
        .clk        (clk),
        .rst        (rst),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_line    (in_line),
        .resteer    (resteer),
        .bp_upd     (bp_upd),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_result (out_result)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #CLK_HALF clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Reporting
    // ------------------------------------------------------------------------

    // Inputs change and outputs are sampled just after the edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic report_mismatch(string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_failure(string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic abort_run(string what);
        $display("timeout at %0t: %s", $time, what);
        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors + 1);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic finish_test(string name);
        tests_done++;
        $display("test %0d %s done, errors so far %0d", tests_done, name, errors);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    // Link registers x1 and x5 show up half the time
    function automatic logic [4:0] pick_reg();
        case ($urandom % 4)
            0: return 5'd0;
            1: return 5'd1;
            2: return 5'd5;
            default: return 5'($urandom);
        endcase
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] inst;
        inst = $urandom;
        case ($urandom % 8)
            0: inst[6:0] = 7'b1101111;
            1: inst[6:0] = 7'b1100111;
            2: inst[6:0] = 7'b1100011;
            3: inst[6:0] = 7'b0110011;
            4: inst[6:0] = 7'b0100011;
            5: inst[6:0] = 7'b0110111;
            // Left random, often compressed or illegal
            default: ;
        endcase
        return inst;
    endfunction

    // JAL or JALR with link-heavy register fields
    function automatic logic [31:0] jump_inst();
        logic [31:0] inst;
        inst        = $urandom;
        inst[6:0]   = ($urandom % 2) ? 7'b1101111 : 7'b1100111;
        inst[11:7]  = pick_reg();
        inst[19:15] = pick_reg();
        return inst;
    endfunction

    function automatic fetch_line_t make_item(logic [31:0] inst, bit plant, bit clean);
        fetch_line_t it;
        int          off;
        for (int w = 0; w < `D1_LINE_BITS / 32; w++)
            it.line[32*w +: 32] = $urandom;
        it.region_valid = $urandom;
        it.pc           = $urandom;
        it.exception    = ($urandom % 8) == 0;
        if (clean)
        begin
            // Whole window inside one valid region
            it.pc[3:0]                  = $urandom % 13;
            it.region_valid[it.pc[5:4]] = 1'b1;
            it.exception                = 1'b0;
        end
        else if ($urandom % 4 == 0)
        begin
            // Last bytes of a region, so the window crosses or wraps
            it.pc[3:0] = 13 + $urandom % 3;
        end
        if (plant)
        begin
            off = it.pc[5:0];
            for (int k = 0; k < 4; k++)
                it.line[`D1_LINE_BITS-1-8*((off+k)%64) -: 8] = inst[8*k +: 8];
        end
        return it;
    endfunction

    // ------------------------------------------------------------------------
    // Handshake drivers
    // ------------------------------------------------------------------------

    task automatic send_item(fetch_line_t item, bit keep);
        int n;
        // No training while in flight, so the current history is the one used
        if (keep)
            expect_q.push_back(expected_result(item, predict_from_history()));
        in_line = item;
        in_req  = 1'b1;
        n = 0;
        while (!in_ack)
        begin
            if (n == TIMEOUT)
                abort_run("in_ack never rose");
            next_cycle();
            n++;
        end
        in_req = 1'b0;
        n = 0;
        while (in_ack)
        begin
            if (n == TIMEOUT)
                abort_run("in_ack never fell");
            next_cycle();
            n++;
        end
    endtask

    task automatic wait_offer();
        int n;
        n = 0;
        while (!out_req)
        begin
            if (n == TIMEOUT)
                abort_run("out_req never rose");
            next_cycle();
            n++;
        end
    endtask

    task automatic recv_item(int delay);
        int         n;
        d1_result_t exp;
        d1_result_t held;
        wait_offer();
        held = out_result;
        checks++;
        if (expect_q.size() == 0)
            report_failure("an item was offered that was never sent or was flushed");
        else
        begin
            exp = expect_q.pop_front();
            checks++;
            if (out_result !== exp)
                report_mismatch($sformatf("pc %h got %h expected %h",
                                          exp.pc, out_result, exp));
        end
        // Offer must hold until acknowledged
        for (int i = 0; i < delay; i++)
        begin
            next_cycle();
            checks++;
            if (!out_req || out_result !== held)
                report_mismatch("offer changed before out_ack");
        end
        out_ack = 1'b1;
        n = 0;
        while (out_req)
        begin
            if (n == TIMEOUT)
                abort_run("out_req never fell");
            next_cycle();
            n++;
        end
        out_ack = 1'b0;
    endtask

    // Nothing more may come out once the scoreboard is drained
    task automatic check_idle(int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            next_cycle();
            checks++;
            if (out_req)
                report_failure("an extra item was offered");
        end
        checks++;
        if (expect_q.size() != 0)
            report_failure($sformatf("%0d items never arrived", expect_q.size()));
    endtask

    task automatic train_pulse(logic taken);
        bp_upd.valid = 1'b1;
        bp_upd.taken = taken;
        bp_upd.bhr   = bhr_ref;
        next_cycle();
        bp_upd = '0;
        train_counter(bhr_ref, taken);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial
    begin
        bit bias;
        seed_draw  = $urandom(32'hbc79_dcc0);
        errors     = 0;
        checks     = 0;
        tests_done = 0;
        rst        = 1'b1;
        in_req     = 1'b0;
        in_line    = '0;
        resteer    = 1'b0;
        bp_upd     = '0;
        out_ack    = 1'b0;
        reset_counters();
        repeat (3)
            @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // Quiet outputs out of reset, then one item through
        checks++;
        if (in_ack !== 1'b0 || out_req !== 1'b0 || out_result.resteer !== 1'b0
            || out_result.resteer_taken !== 1'b0 || out_result.resteer_target !== '0
            || out_result.ras_push !== 1'b0 || out_result.ras_pop !== 1'b0
            || out_result.ras_ret_addr !== '0)
            report_mismatch("handshake or resteer outputs not low after reset");
        send_item(make_item(random_inst(), 1'b1, 1'b1), 1'b1);
        recv_item(0);
        finish_test("reset and first item");

        // Wrapping and region-crossing windows come from make_item
        repeat (40)
        begin
            send_item(make_item(random_inst(), $urandom % 2, 1'b0), 1'b1);
            recv_item($urandom % 2);
        end
        finish_test("random lines");

        // A quarter of the jumps get random validity and exception
        repeat (30)
        begin
            send_item(make_item(jump_inst(), 1'b1, ($urandom % 4) != 0), 1'b1);
            recv_item(0);
        end
        finish_test("jumps and return stack");

        // Biased runs push the history toward all ones or all zeros
        repeat (24)
        begin
            bias = $urandom % 2;
            repeat (10 + $urandom % 6)
                train_pulse((($urandom % 8) != 0) ? bias : !bias);
            send_item(make_item(32'h0000_0063 | ($urandom & 32'hffff_ff80),
                                1'b1, 1'b1), 1'b1);
            recv_item(0);
        end
        finish_test("trained branches");

        // Producer and slow consumer run together
        fork
            begin
                repeat (24)
                    send_item(make_item(random_inst(), 1'b1, $urandom % 2), 1'b1);
            end
            begin
                repeat (24)
                    recv_item($urandom % 6);
            end
        join
        check_idle(8);
        finish_test("back-pressure ordering");

        // Second item sits in the input slot behind an unacknowledged offer
        send_item(make_item(random_inst(), 1'b1, 1'b1), 1'b1);
        wait_offer();
        send_item(make_item(jump_inst(), 1'b1, 1'b1), 1'b0);
        resteer = 1'b1;
        next_cycle();
        resteer = 1'b0;
        recv_item(2);
        send_item(make_item(random_inst(), 1'b1, 1'b1), 1'b1);
        recv_item(0);
        check_idle(8);
        finish_test("resteer flush");

        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: all.f
+incdir+hw
+incdir+sim
hw/d1_fetch_pkg.sv
hw/d1_bp_pkg.sv
hw/byte_rotator.sv
hw/predecoder.sv
hw/branch_pht.sv
hw/d1_stage.sv
sim/d1_tb.sv

// File: Bender.yml
package:
  name: d1_stage

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/d1_fetch_pkg.sv
      - hw/d1_bp_pkg.sv
      - hw/byte_rotator.sv
      - hw/predecoder.sv
      - hw/branch_pht.sv
      - hw/d1_stage.sv
  - target: test
    include_dirs:
      - hw
      - sim
    files:
      - sim/d1_tb.sv
